// ==== src/rv_isa_pkg.sv ====
// RV32I word and register-index types, opcode and funct3 constants
package rv_isa_pkg;

    typedef logic [31:0] word_t;    // Data, address or instruction word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  opcode_t;  // instr[6:2]

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////

    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_JAL    = 5'b11011;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_BRANCH = 5'b11000;
    localparam opcode_t OPC_LOAD   = 5'b00000;
    localparam opcode_t OPC_STORE  = 5'b01000;
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_OP     = 5'b01100;

    ////////////////////////////////////////
    // funct3 encodings
    ////////////////////////////////////////

    // Branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;  // Also sub for OP with bit 30
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;  // sra when bit 30 set
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

endpackage

// ==== src/exec_pkg.sv ====
// Execute-stage types: instruction class, memory parameter field, shift amount
package exec_pkg;

    ////////////////////////////////////////
    // Instruction class
    ////////////////////////////////////////

    // One-hot, all zero for a no-op
    typedef logic [3:0] instr_class_t;

    localparam int CLS_ALU   = 0;  // LUI, AUIPC, OP-IMM, OP
    localparam int CLS_JDIR  = 1;  // JAL, JALR
    localparam int CLS_JCOND = 2;  // BRANCH
    localparam int CLS_MEM   = 3;  // LOAD, STORE

    ////////////////////////////////////////
    // Memory request parameters
    ////////////////////////////////////////

    // {rd[4:0], funct3[2:0], store}
    typedef logic [8:0] mem_para_t;

    // Shift amount for sll/srl/sra
    typedef logic [4:0] shamt_t;

endpackage

// ==== src/instr_decode.sv ====
// Instruction classification, register selects and immediate generation
module instr_decode
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  word_t        instr,
    input  logic         vld,
    output instr_class_t iclass,
    output reg_idx_t     rd_sel,
    output reg_idx_t     rs0_sel,
    output reg_idx_t     rs1_sel,
    output word_t        imm
);

    opcode_t  opcode;
    reg_idx_t rd_field;
    reg_idx_t rs0_field;
    reg_idx_t rs1_field;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_b;
    word_t    imm_u;
    word_t    imm_j;

    assign opcode    = instr[6:2];
    assign rd_field  = instr[11:7];
    assign rs0_field = instr[19:15];
    assign rs1_field = instr[24:20];

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        case (opcode)
            OPC_LUI, OPC_AUIPC:                imm = imm_u;
            OPC_JAL:                           imm = imm_j;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:    imm = imm_i;
            OPC_BRANCH:                        imm = imm_b;
            OPC_STORE:                         imm = imm_s;
            default:                           imm = '0;
        endcase
    end

    ////////////////////////////////////////
    // Class and register selects
    ////////////////////////////////////////

    always_comb
    begin
        iclass  = '0;   // No-op unless matched below
        rd_sel  = '0;
        rs0_sel = '0;
        rs1_sel = '0;
        if (vld && instr[1:0] == 2'b11)
        begin
            case (opcode)
                OPC_LUI, OPC_AUIPC:
                begin
                    iclass[CLS_ALU] = 1'b1;
                    rd_sel          = rd_field;   // rs0 stays x0 for LUI
                end
                OPC_JAL:
                begin
                    iclass[CLS_JDIR] = 1'b1;
                    rd_sel           = rd_field;
                end
                OPC_JALR:
                begin
                    iclass[CLS_JDIR] = 1'b1;
                    rd_sel           = rd_field;
                    rs0_sel          = rs0_field;
                end
                OPC_BRANCH:
                begin
                    iclass[CLS_JCOND] = 1'b1;
                    rs0_sel           = rs0_field;
                    rs1_sel           = rs1_field;
                end
                OPC_LOAD:
                begin
                    iclass[CLS_MEM] = 1'b1;
                    rs0_sel         = rs0_field;  // rd goes out in mem_para
                end
                OPC_STORE:
                begin
                    iclass[CLS_MEM] = 1'b1;
                    rs0_sel         = rs0_field;
                    rs1_sel         = rs1_field;
                end
                OPC_OP_IMM:
                begin
                    iclass[CLS_ALU] = 1'b1;
                    rd_sel          = rd_field;
                    rs0_sel         = rs0_field;
                end
                OPC_OP:
                begin
                    iclass[CLS_ALU] = 1'b1;
                    rd_sel          = rd_field;
                    rs0_sel         = rs0_field;
                    rs1_sel         = rs1_field;
                end
                default:
                begin
                    iclass = '0;
                end
            endcase
        end
    end

endmodule

// ==== src/alu.sv ====
// Operand selection and register result computation
module alu
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  word_t instr,
    input  word_t pc,
    input  word_t rs0_word,
    input  word_t rs1_word,
    input  word_t imm,
    output word_t rg_result
);

    opcode_t opcode;
    funct3_t funct3;
    word_t   operand1;
    word_t   operand2;
    word_t   sum;
    word_t   shift_left;
    word_t   shift_right;
    shamt_t  shamt;
    logic    is_sub;
    logic    is_arith;
    logic    lt_signed;
    logic    lt_unsigned;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];

    ////////////////////////////////////////
    // Operands
    ////////////////////////////////////////

    always_comb
    begin
        case (opcode)
            OPC_AUIPC, OPC_JAL, OPC_JALR: operand1 = pc;
            default:                      operand1 = rs0_word;
        endcase
    end

    always_comb
    begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: operand2 = imm;         // U immediate
            OPC_JAL, OPC_JALR:  operand2 = 32'd4;       // Link value
            OPC_OP_IMM:         operand2 = imm;         // I immediate
            default:            operand2 = rs1_word;
        endcase
    end

    ////////////////////////////////////////
    // Function units
    ////////////////////////////////////////

    assign is_sub   = (opcode == OPC_OP) && instr[30];
    assign is_arith = instr[30];
    assign sum      = is_sub ? (operand1 - operand2) : (operand1 + operand2);

    assign shamt       = operand2[4:0];
    assign shift_left  = operand1 << shamt;
    assign shift_right = is_arith ? word_t'($signed(operand1) >>> shamt) : (operand1 >> shamt);

    assign lt_signed   = $signed(operand1) < $signed(operand2);
    assign lt_unsigned = operand1 < operand2;

    always_comb
    begin
        rg_result = sum;    // LUI, AUIPC and links
        if (opcode == OPC_OP || opcode == OPC_OP_IMM)
        begin
            case (funct3)
                F3_ADD:  rg_result = sum;
                F3_SLL:  rg_result = shift_left;
                F3_SLT:  rg_result = {31'b0, lt_signed};
                F3_SLTU: rg_result = {31'b0, lt_unsigned};
                F3_XOR:  rg_result = operand1 ^ operand2;
                F3_SRL:  rg_result = shift_right;
                F3_OR:   rg_result = operand1 | operand2;
                F3_AND:  rg_result = operand1 & operand2;
                default: rg_result = sum;
            endcase
        end
    end

endmodule

// ==== src/branch_unit.sv ====
// Branch condition evaluation and jump target computation
module branch_unit
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  word_t        instr,
    input  word_t        pc,
    input  word_t        rs0_word,
    input  word_t        rs1_word,
    input  word_t        imm,
    input  instr_class_t iclass,
    output logic         jump_vld,
    output word_t        jump_pc
);

    funct3_t funct3;
    word_t   base;
    logic    taken;

    assign funct3 = instr[14:12];

    always_comb
    begin
        case (funct3)
            F3_BEQ:  taken = (rs0_word == rs1_word);
            F3_BNE:  taken = (rs0_word != rs1_word);
            F3_BLT:  taken = $signed(rs0_word) < $signed(rs1_word);
            F3_BGE:  taken = $signed(rs0_word) >= $signed(rs1_word);
            F3_BLTU: taken = rs0_word < rs1_word;
            F3_BGEU: taken = rs0_word >= rs1_word;
            default: taken = 1'b0;  // Reserved encodings never branch
        endcase
    end

    assign jump_vld = iclass[CLS_JDIR] | (iclass[CLS_JCOND] & taken);

    // JALR is register relative, JAL and branches pc relative
    assign base    = (instr[6:2] == OPC_JALR) ? rs0_word : pc;
    assign jump_pc = base + imm;

endmodule

// ==== src/mem_agu.sv ====
// Load/store address, write data and memory parameter generation
module mem_agu
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  word_t        instr,
    input  word_t        rs0_word,
    input  word_t        rs1_word,
    input  word_t        imm,
    input  instr_class_t iclass,
    output logic         mem_vld,
    output word_t        mem_addr,
    output word_t        mem_wdata,
    output mem_para_t    mem_para
);

    reg_idx_t dest;
    funct3_t  size;
    logic     is_store;

    assign dest     = instr[11:7];
    assign size     = instr[14:12];   // Width and sign of the access
    assign is_store = instr[5];       // Set in the STORE opcode only

    assign mem_vld   = iclass[CLS_MEM];
    assign mem_addr  = rs0_word + imm;  // I imm for loads, S imm for stores
    assign mem_wdata = rs1_word;
    assign mem_para  = {dest, size, is_store};

endmodule

// ==== src/exec_result_reg.sv ====
// Output register stage for all execute results
module exec_result_reg
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      jump_vld_next,
    input  word_t     jump_pc_next,
    input  reg_idx_t  rd_sel,
    input  word_t     rg_result,
    input  logic      mem_vld_next,
    input  mem_para_t mem_para_next,
    input  word_t     mem_addr_next,
    input  word_t     mem_wdata_next,

    output logic      jump_vld,
    output word_t     jump_pc,
    output reg_idx_t  rg_sel,
    output word_t     rg_data,
    output logic      mem_vld,
    output mem_para_t mem_para,
    output word_t     mem_addr,
    output word_t     mem_wdata
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            jump_vld  <= 1'b0;
            jump_pc   <= '0;
            rg_sel    <= '0;    // x0, no register write
            rg_data   <= '0;
            mem_vld   <= 1'b0;
            mem_para  <= '0;
            mem_addr  <= '0;
            mem_wdata <= '0;
        end
        else
        begin
            jump_vld  <= jump_vld_next;
            jump_pc   <= jump_pc_next;
            rg_sel    <= rd_sel;
            rg_data   <= rg_result;
            mem_vld   <= mem_vld_next;
            mem_para  <= mem_para_next;
            mem_addr  <= mem_addr_next;
            mem_wdata <= mem_wdata_next;
        end
    end

endmodule

// ==== src/exec_unit.sv ====
// Execute stage top level: decode, ALU, branch unit, AGU and output register
module exec_unit
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // From issue
    input  word_t     instr,
    input  word_t     pc,
    input  logic      vld,

    // Register file, answered in the same cycle
    output reg_idx_t  rs0_sel,
    output reg_idx_t  rs1_sel,
    input  word_t     rs0_word,
    input  word_t     rs1_word,

    // To fetch
    output logic      jump_vld,
    output word_t     jump_pc,

    // Register write back
    output reg_idx_t  rg_sel,
    output word_t     rg_data,

    // To memory buffer
    output logic      mem_vld,
    output mem_para_t mem_para,
    output word_t     mem_addr,
    output word_t     mem_wdata
);

    instr_class_t iclass;
    reg_idx_t     rd_sel;
    word_t        imm;
    word_t        rg_result;
    logic         br_jump_vld;
    word_t        br_jump_pc;
    logic         agu_mem_vld;
    word_t        agu_mem_addr;
    word_t        agu_mem_wdata;
    mem_para_t    agu_mem_para;

    instr_decode u_decode (
        .instr   (instr),
        .vld     (vld),
        .iclass  (iclass),
        .rd_sel  (rd_sel),
        .rs0_sel (rs0_sel),
        .rs1_sel (rs1_sel),
        .imm     (imm)
    );

    alu u_alu (
        .instr     (instr),
        .pc        (pc),
        .rs0_word  (rs0_word),
        .rs1_word  (rs1_word),
        .imm       (imm),
        .rg_result (rg_result)
    );

    branch_unit u_branch (
        .instr    (instr),
        .pc       (pc),
        .rs0_word (rs0_word),
        .rs1_word (rs1_word),
        .imm      (imm),
        .iclass   (iclass),
        .jump_vld (br_jump_vld),
        .jump_pc  (br_jump_pc)
    );

    mem_agu u_agu (
        .instr     (instr),
        .rs0_word  (rs0_word),
        .rs1_word  (rs1_word),
        .imm       (imm),
        .iclass    (iclass),
        .mem_vld   (agu_mem_vld),
        .mem_addr  (agu_mem_addr),
        .mem_wdata (agu_mem_wdata),
        .mem_para  (agu_mem_para)
    );

    exec_result_reg u_result (
        .clk            (clk),
        .reset          (reset),
        .jump_vld_next  (br_jump_vld),
        .jump_pc_next   (br_jump_pc),
        .rd_sel         (rd_sel),
        .rg_result      (rg_result),
        .mem_vld_next   (agu_mem_vld),
        .mem_para_next  (agu_mem_para),
        .mem_addr_next  (agu_mem_addr),
        .mem_wdata_next (agu_mem_wdata),
        .jump_vld       (jump_vld),
        .jump_pc        (jump_pc),
        .rg_sel         (rg_sel),
        .rg_data        (rg_data),
        .mem_vld        (mem_vld),
        .mem_para       (mem_para),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

endmodule

// ==== tests/exec_model.svh ====
// Reference model: record type, instruction kinds, selects, immediates and expected results
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

localparam logic [2:0] KIND_NOOP   = 3'd0;
localparam logic [2:0] KIND_ALU    = 3'd1;
localparam logic [2:0] KIND_JUMP   = 3'd2;
localparam logic [2:0] KIND_BRANCH = 3'd3;
localparam logic [2:0] KIND_MEM    = 3'd4;

// Expected registered outputs of one instruction
typedef struct packed {
    logic [2:0] kind;
    logic       jump_vld;
    word_t      jump_pc;
    reg_idx_t   rg_sel;
    word_t      rg_data;
    logic       mem_vld;
    mem_para_t  mem_para;
    word_t      mem_addr;
    word_t      mem_wdata;
} expect_t;

function automatic logic [2:0] model_kind(word_t ins, logic v);
    if (!v || ins[1:0] != 2'b11)
        return KIND_NOOP;
    case (ins[6:2])
        OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP: return KIND_ALU;
        OPC_JAL, OPC_JALR:                      return KIND_JUMP;
        OPC_BRANCH:                             return KIND_BRANCH;
        OPC_LOAD, OPC_STORE:                    return KIND_MEM;
        default:                                return KIND_NOOP;
    endcase
endfunction

function automatic reg_idx_t model_rs0_sel(word_t ins, logic v);
    if (model_kind(ins, v) == KIND_NOOP)
        return '0;
    case (ins[6:2])
        OPC_LUI, OPC_AUIPC, OPC_JAL: return '0;   // No source register
        default:                     return ins[19:15];
    endcase
endfunction

function automatic reg_idx_t model_rs1_sel(word_t ins, logic v);
    if (model_kind(ins, v) == KIND_NOOP)
        return '0;
    case (ins[6:2])
        OPC_BRANCH, OPC_STORE, OPC_OP: return ins[24:20];
        default:                       return '0;
    endcase
endfunction

function automatic reg_idx_t model_rd_sel(word_t ins, logic v);
    logic [2:0] kind;
    kind = model_kind(ins, v);
    if (kind == KIND_ALU || kind == KIND_JUMP)
        return ins[11:7];
    return '0;
endfunction

////////////////////////////////////////
// Immediates
////////////////////////////////////////

// All formats share the sign in bit 31 and most of the I layout
function automatic word_t model_imm(word_t ins);
    word_t w;
    w = $signed(ins) >>> 20;
    case (ins[6:2])
        OPC_LUI, OPC_AUIPC:
            w = {ins[31:12], 12'h000};
        OPC_STORE:
            w[4:0] = ins[11:7];
        OPC_BRANCH:
        begin
            w[11]  = ins[7];
            w[4:1] = ins[11:8];
            w[0]   = 1'b0;
        end
        OPC_JAL:
        begin
            w[19:12] = ins[19:12];
            w[11]    = ins[20];
            w[0]     = 1'b0;
        end
        default:
            w = w;   // I format
    endcase
    return w;
endfunction

////////////////////////////////////////
// Results
////////////////////////////////////////

function automatic word_t model_alu(funct3_t f3, word_t x, word_t y, logic alt);
    word_t r;
    case (f3)
        F3_ADD:  r = alt ? (x - y) : (x + y);
        F3_SLL:  r = x << y[4:0];
        F3_SLT:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        F3_SLTU: r = (x < y) ? 32'd1 : 32'd0;
        F3_XOR:  r = x ^ y;
        F3_OR:   r = x | y;
        F3_AND:  r = x & y;
        default:
        begin
            if (alt)
                r = $signed(x) >>> y[4:0];
            else
                r = x >> y[4:0];
        end
    endcase
    return r;
endfunction

function automatic word_t model_rg_data(word_t ins, word_t p, word_t a, word_t b);
    logic srai;
    srai = ins[30] && ins[14:12] == F3_SRL;   // OP-IMM never subtracts
    case (ins[6:2])
        OPC_LUI:           return a + model_imm(ins);
        OPC_AUIPC:         return p + model_imm(ins);
        OPC_JAL, OPC_JALR: return p + 32'd4;
        OPC_OP_IMM:        return model_alu(ins[14:12], a, model_imm(ins), srai);
        OPC_OP:            return model_alu(ins[14:12], a, b, ins[30]);
        default:           return '0;
    endcase
endfunction

function automatic logic model_taken(funct3_t f3, word_t a, word_t b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        F3_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t model_jump_pc(word_t ins, word_t p, word_t a);
    if (ins[6:2] == OPC_JALR)
        return a + model_imm(ins);
    return p + model_imm(ins);
endfunction

function automatic expect_t model_expect(word_t ins, logic v, word_t p, word_t a, word_t b);
    expect_t e;
    e.kind      = model_kind(ins, v);
    e.jump_vld  = (e.kind == KIND_JUMP) ||
                  (e.kind == KIND_BRANCH && model_taken(ins[14:12], a, b));
    e.jump_pc   = model_jump_pc(ins, p, a);
    e.rg_sel    = model_rd_sel(ins, v);
    e.rg_data   = model_rg_data(ins, p, a, b);
    e.mem_vld   = (e.kind == KIND_MEM);
    e.mem_para  = {ins[11:7], ins[14:12], ins[6:2] == OPC_STORE};
    e.mem_addr  = a + model_imm(ins);   // I for loads, S for stores
    e.mem_wdata = b;
    return e;
endfunction

`endif

// ==== tests/exec_unit_tb.sv ====
// Execute stage testbench: clock, reset, random instruction stream, checks and timeout
module exec_unit_tb
    import rv_isa_pkg::*, exec_pkg::*;
();

    localparam int NUM_INSTR      = 2000;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + 100;   // Stream plus reset and margin
    localparam int DRIVE_DELAY    = 1;
    localparam int SAMPLE_DELAY   = 2;

    logic      clk = 1'b0;
    logic      reset;
    word_t     instr;
    word_t     pc;
    logic      vld;
    word_t     rs0_word;
    word_t     rs1_word;
    reg_idx_t  rs0_sel;
    reg_idx_t  rs1_sel;
    logic      jump_vld;
    word_t     jump_pc;
    reg_idx_t  rg_sel;
    word_t     rg_data;
    logic      mem_vld;
    mem_para_t mem_para;
    word_t     mem_addr;
    word_t     mem_wdata;

    integer    seed;
    int        cycle_cnt = 0;

    `include "exec_model.svh"

    expect_t    exp_q[$];
    expect_t    done_exp;
    logic [2:0] cur_kind;
    reg_idx_t   cur_rs0_sel;
    reg_idx_t   cur_rs1_sel;

    exec_unit u_dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .pc        (pc),
        .vld       (vld),
        .rs0_sel   (rs0_sel),
        .rs1_sel   (rs1_sel),
        .rs0_word  (rs0_word),
        .rs1_word  (rs1_word),
        .jump_vld  (jump_vld),
        .jump_pc   (jump_pc),
        .rg_sel    (rg_sel),
        .rg_data   (rg_data),
        .mem_vld   (mem_vld),
        .mem_para  (mem_para),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES)
        begin
            $display("Timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "Stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic string kind_name(logic [2:0] kind);
        case (kind)
            KIND_ALU:    return "alu";
            KIND_JUMP:   return "jump";
            KIND_BRANCH: return "branch";
            KIND_MEM:    return "mem";
            default:     return "noop";
        endcase
    endfunction

    function automatic opcode_t opcode_for(int k);
        case (k)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OP_IMM;
            default: return OPC_OP;
        endcase
    endfunction

    // Valid branch compares, and funct7 zero except the sub/sra bit
    function automatic word_t legalize_fields(word_t ins);
        word_t w;
        w = ins;
        case (w[6:2])
            OPC_BRANCH:
            begin
                if (w[14:13] == 2'b01)
                    w[14] = 1'b1;
            end
            OPC_OP:
            begin
                w[31:25] = 7'b0;
                if (w[14:12] == F3_ADD || w[14:12] == F3_SRL)
                    w[30] = ins[30];
            end
            OPC_OP_IMM:
            begin
                if (w[14:12] == F3_SLL || w[14:12] == F3_SRL)
                begin
                    w[31:25] = 7'b0;
                    w[30]    = (w[14:12] == F3_SRL) && ins[30];
                end
            end
            default:
                w = ins;
        endcase
        return w;
    endfunction

    task automatic check_value(string what, logic [31:0] expv, logic [31:0] actv);
        assert (actv === expv)
        else
        begin
            $display("ERR %s: expected %h, actual %h", what, expv, actv);
            $display("** FAIL **");
            $fatal(1, "Stopped on the first mismatch");
        end
    endtask

    task automatic check_idle(string phase);
        check_value({phase, " jump_vld"}, 32'(1'b0), 32'(jump_vld));
        check_value({phase, " mem_vld"}, 32'(1'b0), 32'(mem_vld));
        check_value({phase, " rg_sel"}, 32'(5'd0), 32'(rg_sel));
    endtask

    task automatic check_selects();
        check_value({kind_name(cur_kind), " rs0_sel"}, 32'(cur_rs0_sel), 32'(rs0_sel));
        check_value({kind_name(cur_kind), " rs1_sel"}, 32'(cur_rs1_sel), 32'(rs1_sel));
    endtask

    task automatic check_outputs(expect_t e);
        string name;
        name = kind_name(e.kind);
        check_value({name, " jump_vld"}, 32'(e.jump_vld), 32'(jump_vld));
        check_value({name, " mem_vld"}, 32'(e.mem_vld), 32'(mem_vld));
        check_value({name, " rg_sel"}, 32'(e.rg_sel), 32'(rg_sel));
        if (e.kind == KIND_ALU || e.kind == KIND_JUMP)
            check_value({name, " rg_data"}, e.rg_data, rg_data);
        if (e.kind == KIND_JUMP || e.kind == KIND_BRANCH)
            check_value({name, " jump_pc"}, e.jump_pc, jump_pc);
        if (e.kind == KIND_MEM)
        begin
            check_value({name, " mem_addr"}, e.mem_addr, mem_addr);
            check_value({name, " mem_wdata"}, e.mem_wdata, mem_wdata);
            check_value({name, " mem_para"}, 32'(e.mem_para), 32'(mem_para));
        end
    endtask

    // One random instruction, with the register file answering the selects
    task automatic issue_random();
        word_t ins;
        word_t r;
        word_t a;
        word_t b;
        word_t p;
        logic  v;
        int    pick;
        r    = $random(seed);
        pick = int'(r[3:0]);
        ins  = $random(seed);
        if (pick < 13)
        begin
            r        = $random(seed);
            ins[6:2] = opcode_for(int'(r[7:0]) % 9);
            ins[1:0] = 2'b11;
            ins      = legalize_fields(ins);
        end
        else if (pick < 15)
        begin
            ins[1:0] = 2'b11;
            while (model_kind(ins, 1'b1) != KIND_NOOP)
            begin
                r        = $random(seed);
                ins[6:2] = r[4:0];
            end
        end
        else if (ins[1:0] == 2'b11)
            ins[1:0] = 2'b01;   // Compressed space
        r = $random(seed);
        v = (r[2:0] != 3'b000);
        p = $random(seed);
        a = $random(seed);
        b = $random(seed);
        if (r[5:3] == 3'b000)
            b = a;   // Equal compares, shift by own value
        cur_kind    = model_kind(ins, v);
        cur_rs0_sel = model_rs0_sel(ins, v);
        cur_rs1_sel = model_rs1_sel(ins, v);
        if (cur_rs0_sel == 5'd0)
            a = '0;   // x0 reads as zero
        if (cur_rs1_sel == 5'd0)
            b = '0;
        instr    = ins;
        vld      = v;
        pc       = p;
        rs0_word = a;
        rs1_word = b;
        exp_q.push_back(model_expect(ins, v, p, a, b));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        seed     = 32'h92c24bac;
        reset    = 1'b1;
        instr    = '0;
        pc       = '0;
        vld      = 1'b0;
        rs0_word = '0;
        rs1_word = '0;
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            // Jumps to x1 and stores that reset must hold off
            instr = (i % 2 == 0) ? {20'h0, 5'd1, OPC_JAL, 2'b11}
                                 : {25'h0, OPC_STORE, 2'b11};
            vld   = 1'b1;
            @(posedge clk);
            #(DRIVE_DELAY);
            check_idle("reset");
        end
        reset = 1'b0;
        vld   = 1'b0;   // Store stays on the bus with vld low
        @(posedge clk);
        #(DRIVE_DELAY);
        check_idle("after reset");

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            issue_random();
            #(SAMPLE_DELAY);
            check_selects();
            @(posedge clk);
            #(DRIVE_DELAY);
            done_exp = exp_q.pop_front();
            check_outputs(done_exp);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== exec_unit.f ====
+incdir+tests
src/rv_isa_pkg.sv
src/exec_pkg.sv
src/instr_decode.sv
src/alu.sv
src/branch_unit.sv
src/mem_agu.sv
src/exec_result_reg.sv
src/exec_unit.sv
tests/exec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_unit_tb -f exec_unit.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vexec_unit_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
